/* dv/barrel_tb.sv */
//////////////////////////////
// barrel hazard testbench
// table of launches, ticks and pixel probes against a lane model
//////////////////////////////

`timescale 1ns/1ps

module barrel_tb;

   typedef enum int {
      op_launch,
      op_tick,
      op_probe,
      op_idle
   } op_t;

   typedef struct {
      op_t op;
      int count;
      int h;
      int v;
      int exp;                         // busy mask, or 1 for a barrel hit on a probe
   } row_t;

   logic clk65MHz = 1'b0;
   logic rst;
   logic launch;
   logic frame_tick;
   barrel_pkg::coord_t hcount;
   barrel_pkg::coord_t vcount;
   logic hsync;
   logic vsync;
   barrel_pkg::rgb_t rgb_in;
   logic hs;
   logic vs;
   logic [3:0] r;
   logic [3:0] g;
   logic [3:0] b;
   barrel_pkg::lane_mask_t busy;
   barrel_pkg::drop_cnt_t dropped;

   row_t rows[$];
   integer seed;
   int row_errs;
   int n_ok;
   int n_bad;

   // lane model
   barrel_pkg::lane_mask_t m_busy;
   int m_x [barrel_pkg::num_lanes];
   int m_drop;

   always #50 clk65MHz = ~clk65MHz;

   barrel_top dut_i (
      .clk65MHz(clk65MHz),
      .rst(rst),
      .launch(launch),
      .frame_tick(frame_tick),
      .hcount(hcount),
      .vcount(vcount),
      .hsync(hsync),
      .vsync(vsync),
      .rgb_in(rgb_in),
      .hs(hs),
      .vs(vs),
      .r(r),
      .g(g),
      .b(b),
      .busy(busy),
      .dropped(dropped)
   );

   function automatic int lane_y(int i);
      return barrel_pkg::row_y0 + i * barrel_pkg::row_pitch;
   endfunction

   function automatic logic square_hit(int h, int v);
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < barrel_pkg::num_lanes; i++) begin
         if (m_busy[i] && h >= m_x[i] && h < m_x[i] + barrel_pkg::barrel_size &&
             v >= lane_y(i) && v < lane_y(i) + barrel_pkg::barrel_size) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   function automatic int row_cycles(row_t row);
      return 2 * row.count + 4;
   endfunction

   task automatic add_row(op_t op, int count, int h, int v, int exp);
      row_t row;
      row = '{op, count, h, v, exp};
      rows.push_back(row);
   endtask

   task automatic pick_lane();
      int free;
      free = -1;
      for (int i = barrel_pkg::num_lanes - 1; i >= 0; i--) begin
         if (!m_busy[i]) begin
            free = i;                  // lowest idle lane wins
         end
      end
      if (free >= 0) begin
         m_busy[free] = 1'b1;
         m_x[free] = barrel_pkg::start_x;
      end else if (m_drop < 255) begin
         m_drop++;
      end
   endtask

   task automatic advance_lanes();
      for (int i = 0; i < barrel_pkg::num_lanes; i++) begin
         if (m_busy[i]) begin
            if (m_x[i] + barrel_pkg::step_x >= barrel_pkg::end_x) begin
               m_busy[i] = 1'b0;       // retired at the right edge
            end else begin
               m_x[i] = m_x[i] + barrel_pkg::step_x;
            end
         end
      end
   endtask

   task automatic pulse_strobe(logic is_tick, int count);
      repeat (count) begin
         @(posedge clk65MHz);
         if (is_tick) frame_tick <= 1'b1;
         else launch <= 1'b1;
         @(posedge clk65MHz);
         frame_tick <= 1'b0;
         launch <= 1'b0;
         if (is_tick) begin
            advance_lanes();
         end else begin
            @(negedge clk65MHz);
            // one cycle after the launch the lane is not busy yet
            assert (busy === m_busy) else begin
               $display("ERROR @%0t ns: busy %b one cycle after launch, expected %b",
                        $time, busy, m_busy);
               row_errs++;
            end
            pick_lane();
         end
      end
      @(posedge clk65MHz);             // launch to busy is 2 cycles
      @(negedge clk65MHz);
   endtask

   task automatic check_state(int exp);
      assert (busy === m_busy && dropped === barrel_pkg::drop_cnt_t'(m_drop)) else begin
         $display("ERROR @%0t ns: busy %b dropped %0d, expected busy %b dropped %0d",
                  $time, busy, dropped, m_busy, m_drop);
         row_errs++;
      end
      assert (m_busy == barrel_pkg::lane_mask_t'(exp)) else begin
         $display("table row expects busy %b but the lane model gives %b", exp[3:0], m_busy);
         row_errs++;
      end
   endtask

   // drive one pixel, then check the registered copy one cycle later
   task automatic send_pixel(int h, int v, output logic hit);
      barrel_pkg::rgb_t bg;
      barrel_pkg::rgb_t exp_rgb;
      logic hs_v;
      logic vs_v;
      bg = $random(seed);
      hs_v = $random(seed);
      vs_v = $random(seed);
      @(posedge clk65MHz);
      hcount <= barrel_pkg::coord_t'(h);
      vcount <= barrel_pkg::coord_t'(v);
      hsync <= hs_v;
      vsync <= vs_v;
      rgb_in <= bg;
      @(posedge clk65MHz);
      hsync <= ~hs_v;                  // the next input must not show yet
      vsync <= ~vs_v;
      rgb_in <= ~bg;
      @(negedge clk65MHz);
      hit = square_hit(h, v);
      exp_rgb = hit ? barrel_pkg::barrel_rgb : bg;
      assert ({r, g, b} === exp_rgb && hs === hs_v && vs === vs_v) else begin
         $display("ERROR @%0t ns: pixel (%0d,%0d) gave rgb %h hs %b vs %b, expected %h %b %b",
                  $time, h, v, {r, g, b}, hs, vs, exp_rgb, hs_v, vs_v);
         row_errs++;
      end
   endtask

   task automatic finish_row(string name);
      if (row_errs == 0) begin
         n_ok++;
         $display("%s: ok", name);
      end else begin
         n_bad++;
         $display("%s: %0d mismatches", name, row_errs);
      end
   endtask

   task automatic build_table();
      add_row(op_idle, 4, 0, 0, 4'b0000);
      add_row(op_launch, 1, 0, 0, 4'b0001);
      add_row(op_tick, 126, 0, 0, 4'b0001);
      add_row(op_tick, 1, 0, 0, 4'b0000);       // 127th tick retires lane 0
      add_row(op_launch, 1, 0, 0, 4'b0001);
      add_row(op_tick, 10, 0, 0, 4'b0001);      // lane 0 at x 80
      add_row(op_probe, 0, 90, 100, 1);
      add_row(op_probe, 0, 79, 100, 0);
      add_row(op_probe, 0, 112, 100, 0);
      add_row(op_probe, 0, 90, 95, 0);
      add_row(op_probe, 0, 90, 128, 0);
      add_row(op_probe, 0, 80, 96, 1);
      add_row(op_probe, 0, 111, 127, 1);
      add_row(op_launch, 1, 0, 0, 4'b0011);
      add_row(op_launch, 1, 0, 0, 4'b0111);
      add_row(op_launch, 1, 0, 0, 4'b1111);
      add_row(op_launch, 1, 0, 0, 4'b1111);     // dropped with all lanes full
      add_row(op_tick, 117, 0, 0, 4'b1110);
      add_row(op_launch, 1, 0, 0, 4'b1111);     // lane 0 reused
      add_row(op_probe, 0, 0, 96, 1);
      add_row(op_probe, 0, 31, 127, 1);
      add_row(op_probe, 0, 32, 96, 0);
      add_row(op_probe, 0, 936, 256, 1);
      add_row(op_probe, 0, 968, 256, 0);
      add_row(op_probe, 0, 950, 576, 1);
      add_row(op_tick, 10, 0, 0, 4'b0001);
      add_row(op_probe, 0, 85, 100, 1);
      add_row(op_idle, 8, 0, 0, 4'b0001);
   endtask

   initial begin
      row_t row;
      logic hit;
      seed = 32'h55ab;
      n_ok = 0;
      n_bad = 0;
      rst <= 1'b1;
      launch <= 1'b0;
      frame_tick <= 1'b0;
      hcount <= '0;
      vcount <= '0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      rgb_in <= '0;
      m_busy = '0;
      m_drop = 0;
      foreach (m_x[i]) m_x[i] = 0;
      build_table();

      repeat (15) @(posedge clk65MHz);
      @(negedge clk65MHz);
      row_errs = 0;
      assert (busy === '0 && dropped === '0 && hs === 1'b0 && vs === 1'b0 && {r, g, b} === '0)
      else begin
         $display("ERROR @%0t ns: outputs not cleared by reset", $time);
         row_errs++;
      end
      finish_row("reset");
      @(posedge clk65MHz);
      rst <= 1'b0;

      foreach (rows[k]) begin
         row = rows[k];
         row_errs = 0;
         case (row.op)
            op_launch, op_tick: begin
               pulse_strobe(row.op == op_tick, row.count);
               check_state(row.exp);
            end
            op_probe: begin
               send_pixel(row.h, row.v, hit);
               assert (hit == row.exp[0]) else begin
                  $display("table row expects hit %0d but the lane model gives %0d",
                           row.exp, hit);
                  row_errs++;
               end
            end
            default: begin
               repeat (row.count) begin
                  send_pixel($random(seed) & 32'h3ff, $random(seed) & 32'h3ff, hit);
               end
               check_state(row.exp);
            end
         endcase
         finish_row($sformatf("row %0d %s", k, row.op.name()));
      end

      $display("rows finished: %0d ok, %0d with errors", n_ok, n_bad);
      if (n_bad == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // watchdog sized from the table
   initial begin
      int limit;
      @(posedge clk65MHz);
      limit = 16 + 200;
      foreach (rows[k]) limit += row_cycles(rows[k]);
      repeat (limit) @(posedge clk65MHz);
      $display("timeout: the run was still going after %0d clock cycles", limit);
      $display("test failed");
      $finish;
   end

endmodule

/* rtl/barrel_draw.sv */
//////////////////////////////
// barrel drawer
// paints a square per rolling barrel over the pixel stream
//////////////////////////////

`timescale 1ns/1ps

module barrel_draw (
   input  logic clk65MHz,
   input  logic rst,
   vga_if.snk pix_in,
   vga_if.src pix_out,
   barrel_if.view lanes [barrel_pkg::num_lanes]
);

   barrel_pkg::lane_mask_t h_in;
   barrel_pkg::lane_mask_t v_in;
   barrel_pkg::lane_mask_t hit;
   barrel_pkg::rgb_t rgb_mix;

   for (genvar i = 0; i < barrel_pkg::num_lanes; i++) begin : g_hit
      // half-open span [x, x + size)
      assign h_in[i] = (pix_in.hcount >= lanes[i].x) &&
                       (pix_in.hcount < lanes[i].x + barrel_pkg::barrel_size);
      assign v_in[i] = (pix_in.vcount >= lanes[i].y) &&
                       (pix_in.vcount < lanes[i].y + barrel_pkg::barrel_size);
      assign hit[i] = lanes[i].busy && h_in[i] && v_in[i];
   end

   // barrels are flat colour on top of the background
   assign rgb_mix = (|hit) ? barrel_pkg::barrel_rgb : pix_in.rgb;

   // all fields go through the same single stage
   always_ff @(posedge clk65MHz) begin
      if (rst) begin
         pix_out.hcount <= '0;
         pix_out.vcount <= '0;
         pix_out.hsync <= 1'b0;
         pix_out.vsync <= 1'b0;
         pix_out.rgb <= '0;
      end else begin
         pix_out.hcount <= pix_in.hcount;
         pix_out.vcount <= pix_in.vcount;
         pix_out.hsync <= pix_in.hsync;
         pix_out.vsync <= pix_in.vsync;
         pix_out.rgb <= rgb_mix;
      end
   end

endmodule

/* rtl/barrel_if.sv */
//////////////////////////////
// barrel lane link
// start, busy and position of one lane
//////////////////////////////

`timescale 1ns/1ps

interface barrel_if;

   logic start;               // one-cycle pulse from the launcher
   logic busy;
   barrel_pkg::coord_t x;
   barrel_pkg::coord_t y;

   modport ctl (
      output start,
      input busy
   );

   modport mover (
      input start,
      output busy, x, y
   );

   modport view (
      input busy, x, y
   );

endinterface

/* rtl/barrel_launcher.sv */
//////////////////////////////
// barrel launcher
// sends each launch to the lowest idle lane, counts drops
//////////////////////////////

`timescale 1ns/1ps

module barrel_launcher (
   input  logic clk65MHz,
   input  logic rst,
   input  logic launch,
   barrel_if.ctl lanes [barrel_pkg::num_lanes],
   output barrel_pkg::drop_cnt_t dropped
);

   barrel_pkg::lane_mask_t busy;
   barrel_pkg::lane_mask_t avail;
   barrel_pkg::lane_mask_t pick;
   barrel_pkg::lane_mask_t start_q;

   for (genvar i = 0; i < barrel_pkg::num_lanes; i++) begin : g_lane
      assign busy[i] = lanes[i].busy;
      assign lanes[i].start = start_q[i];
   end

   // a lane whose start is still in flight counts as taken
   assign avail = ~(busy | start_q);

   // lowest set bit of avail, zero when nothing is free
   assign pick = avail & (~avail + 1'b1);

   always_ff @(posedge clk65MHz) begin
      if (rst) begin
         start_q <= '0;
         dropped <= '0;
      end else begin
         start_q <= launch ? pick : '0;
         if (launch && (avail == '0) && (dropped != '1)) begin
            dropped <= dropped + 1'b1;       // all lanes full
         end
      end
   end

   start_onehot: assert property (
      @(posedge clk65MHz) disable iff (rst)
      $onehot0(start_q)
   ) else $error("more than one lane started at once");

   start_to_idle: assert property (
      @(posedge clk65MHz) disable iff (rst)
      (start_q & busy) == '0
   ) else $error("start sent to a lane that is still rolling");

endmodule

/* rtl/barrel_mover.sv */
//////////////////////////////
// barrel mover
// one lane, rolls a barrel right per frame tick
//////////////////////////////

`timescale 1ns/1ps

module barrel_mover #(
   parameter int unsigned lane = 0
) (
   input  logic clk65MHz,
   input  logic rst,
   input  logic frame_tick,
   barrel_if.mover bus
);

   barrel_pkg::mover_state_t state;
   barrel_pkg::coord_t x;
   barrel_pkg::coord_t x_step;
   logic retire;

   assign x_step = x + barrel_pkg::step_x;
   assign retire = frame_tick && (x_step >= barrel_pkg::end_x);

   always_ff @(posedge clk65MHz) begin
      if (rst) begin
         state <= barrel_pkg::idle;
      end else begin
         case (state)
            barrel_pkg::idle: begin
               if (bus.start) begin
                  state <= barrel_pkg::roll;
               end
            end
            barrel_pkg::roll: begin
               if (retire) begin
                  state <= barrel_pkg::idle;  // reached the right edge
               end
            end
            default: state <= barrel_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clk65MHz) begin
      if ((state == barrel_pkg::idle) && bus.start) begin
         x <= barrel_pkg::start_x;
      end else if ((state == barrel_pkg::roll) && frame_tick && !retire) begin
         x <= x_step;
      end
   end

   assign bus.busy = (state == barrel_pkg::roll);
   assign bus.x = x;
   // each lane sits on its own row
   assign bus.y = barrel_pkg::coord_t'(barrel_pkg::row_y0 + lane * barrel_pkg::row_pitch);

   x_in_range: assert property (
      @(posedge clk65MHz) disable iff (rst)
      (state == barrel_pkg::roll) |-> (x < barrel_pkg::end_x)
   ) else $error("lane %0d rolled past the right edge", lane);

   start_when_idle: assert property (
      @(posedge clk65MHz) disable iff (rst)
      bus.start |-> (state == barrel_pkg::idle)
   ) else $error("lane %0d got start while rolling", lane);

endmodule

/* rtl/barrel_pkg.sv */
//////////////////////////////
// barrel hazard package
// lane count, screen geometry, colours and shared types
//////////////////////////////

package barrel_pkg;

   localparam int num_lanes = 4;

   typedef logic [10:0] coord_t;          // pixel coordinate, x or y
   typedef logic [11:0] rgb_t;            // 4 bits each of r, g, b
   typedef logic [num_lanes-1:0] lane_mask_t;
   typedef logic [7:0] drop_cnt_t;        // saturating

   typedef enum logic {
      idle,
      roll
   } mover_state_t;

   // horizontal motion
   localparam coord_t start_x = 11'd0;
   localparam coord_t step_x = 11'd8;     // per frame tick
   localparam coord_t end_x = 11'd1016;   // barrel leaves the screen here

   // lane rows
   localparam coord_t row_y0 = 11'd96;
   localparam coord_t row_pitch = 11'd160;

   localparam coord_t barrel_size = 11'd32;
   localparam rgb_t barrel_rgb = 12'h840; // brown

endpackage

/* rtl/barrel_top.sv */
//////////////////////////////
// barrel hazard top
// launcher, lane movers and drawer
//////////////////////////////

`timescale 1ns/1ps

module barrel_top (
   input  logic clk65MHz,
   input  logic rst,
   input  logic launch,
   input  logic frame_tick,
   input  barrel_pkg::coord_t hcount,
   input  barrel_pkg::coord_t vcount,
   input  logic hsync,
   input  logic vsync,
   input  barrel_pkg::rgb_t rgb_in,
   output logic hs,
   output logic vs,
   output logic [3:0] r,
   output logic [3:0] g,
   output logic [3:0] b,
   output barrel_pkg::lane_mask_t busy,
   output barrel_pkg::drop_cnt_t dropped
);

   vga_if pix_in ();
   vga_if pix_out ();
   barrel_if lane_if [barrel_pkg::num_lanes] ();

   assign pix_in.hcount = hcount;
   assign pix_in.vcount = vcount;
   assign pix_in.hsync = hsync;
   assign pix_in.vsync = vsync;
   assign pix_in.rgb = rgb_in;

   assign hs = pix_out.hsync;
   assign vs = pix_out.vsync;
   assign {r, g, b} = pix_out.rgb;

   barrel_launcher u_launcher (
      .clk65MHz,
      .rst,
      .launch,
      .lanes(lane_if),
      .dropped
   );

   for (genvar i = 0; i < barrel_pkg::num_lanes; i++) begin : g_lane
      barrel_mover #(
         .lane(i)
      ) u_mover (
         .clk65MHz,
         .rst,
         .frame_tick,
         .bus(lane_if[i])
      );

      assign busy[i] = lane_if[i].busy;
   end

   barrel_draw u_draw (
      .clk65MHz,
      .rst,
      .pix_in(pix_in),
      .pix_out(pix_out),
      .lanes(lane_if)
   );

endmodule

/* rtl/vga_if.sv */
//////////////////////////////
// vga pixel stream
// counters, syncs and colour of one pixel
//////////////////////////////

`timescale 1ns/1ps

interface vga_if;

   barrel_pkg::coord_t hcount;
   barrel_pkg::coord_t vcount;
   logic hsync;
   logic vsync;
   barrel_pkg::rgb_t rgb;

   modport src (
      output hcount, vcount, hsync, vsync, rgb
   );

   modport snk (
      input hcount, vcount, hsync, vsync, rgb
   );

endinterface

/* verilog.f */
rtl/barrel_pkg.sv
rtl/vga_if.sv
rtl/barrel_if.sv
rtl/barrel_launcher.sv
rtl/barrel_mover.sv
rtl/barrel_draw.sv
rtl/barrel_top.sv
dv/barrel_tb.sv
